// File: hdl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    typedef logic [31:0] instr_t;     // One instruction word
    typedef logic [4:0]  reg_addr_t;  // Register file index
    typedef logic [11:0] csr_addr_t;  // CSR address space
    typedef logic [3:0]  alu_op_t;    // {funct7[5], funct3}
    typedef logic [3:0]  byte_en_t;   // One enable per data byte
    typedef logic [2:0]  funct3_t;    // Minor opcode field

    localparam alu_op_t ALU_OP_ADD = 4'b0000;  // Plain add, also the idle code

    // Branch conditions
    localparam funct3_t FUNCT3_BEQ  = 3'b000;
    localparam funct3_t FUNCT3_BNE  = 3'b001;
    localparam funct3_t FUNCT3_BLT  = 3'b100;
    localparam funct3_t FUNCT3_BGE  = 3'b101;
    localparam funct3_t FUNCT3_BLTU = 3'b110;
    localparam funct3_t FUNCT3_BGEU = 3'b111;

    // Load widths
    localparam funct3_t FUNCT3_LB  = 3'b000;
    localparam funct3_t FUNCT3_LH  = 3'b001;
    localparam funct3_t FUNCT3_LW  = 3'b010;
    localparam funct3_t FUNCT3_LBU = 3'b100;
    localparam funct3_t FUNCT3_LHU = 3'b101;

    // Store widths
    localparam funct3_t FUNCT3_SB = 3'b000;
    localparam funct3_t FUNCT3_SH = 3'b001;
    localparam funct3_t FUNCT3_SW = 3'b010;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        SEL_REGS    = 2'd0,  // rs1 and rs2
        SEL_IMM_RS1 = 2'd1,  // rs1 and immediate
        SEL_IMM_PC  = 2'd2   // PC and immediate
    } operand_sel_e;

    typedef enum logic [2:0] {
        BR_NOOP, BR_EQ, BR_NE, BR_LT, BR_LTU, BR_GE, BR_GEU
    } br_op_e;

    typedef enum logic [2:0] {
        LOAD_LB, LOAD_LH, LOAD_LW, LOAD_LBU, LOAD_LHU
    } load_op_e;

    typedef enum logic [1:0] {
        STORE_SB, STORE_SH, STORE_SW
    } store_op_e;

    typedef struct packed {
        alu_op_t      alu_op;       // ALU function
        operand_sel_e operand_sel;  // Operand source pair
        logic         regfile_wr;   // Write back to rd
        logic         rs1_used;     // rs1 is read
        logic         rs2_used;     // rs2 is read
        logic         jump;         // JAL or JALR
        logic         jalr;         // Target from rs1
        br_op_e       br_op;        // Branch condition
        funct3_t      csr_op;       // Bit 2 marks immediate form
        logic         csr_wr;       // CSR gets written
    } exe_ctrl_t;

    typedef struct packed {
        logic      data_rd;   // Memory read
        logic      data_wr;   // Memory write
        logic      is_mem;    // Any data access
        load_op_e  load_op;   // Load width and sign
        store_op_e store_op;  // Store width
        byte_en_t  byte_en;   // Store lane enables
    } mem_ctrl_t;

    typedef struct packed {
        reg_addr_t  rs1;       // Source 1
        reg_addr_t  rs2;       // Source 2
        reg_addr_t  rd;        // Destination
        csr_addr_t  csr_addr;  // CSR selected by SYSTEM
        logic [4:0] csr_imm;   // Zero-extended CSR immediate
    } reg_fields_t;

endpackage

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module imm_gen #(
    parameter int XLEN = 32  // Datapath width, 32 or more
) (
    input  wire rv_decode_pkg::instr_t instr_i,  // Instruction word
    output logic [XLEN-1:0]            imm_o     // Extended immediate
);

    rv_decode_pkg::opcode_e opcode;  // Major opcode selects the format
    logic signed [31:0]     imm32;   // Immediate before widening

    assign opcode = rv_decode_pkg::opcode_e'(instr_i[6:0]);

    always_comb begin
        imm32 = '0;  // No immediate for unknown opcodes
        case (opcode)
            rv_decode_pkg::OPC_LUI,
            rv_decode_pkg::OPC_AUIPC: begin
                imm32 = {instr_i[31:12], 12'b0};  // U format, upper 20 bits
            end
            rv_decode_pkg::OPC_JALR,
            rv_decode_pkg::OPC_LOAD,
            rv_decode_pkg::OPC_OP_IMM: begin
                imm32 = {{20{instr_i[31]}}, instr_i[31:20]};  // I format
            end
            rv_decode_pkg::OPC_STORE: begin
                imm32 = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};  // S format
            end
            rv_decode_pkg::OPC_BRANCH: begin
                imm32 = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};  // B format, halfword offset
            end
            rv_decode_pkg::OPC_JAL: begin
                imm32 = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};  // J format, halfword offset
            end
            default: imm32 = '0;
        endcase
    end

    assign imm_o = XLEN'(imm32);  // Sign extends, as RV64 LUI does

    // Control transfer offsets stay halfword aligned
    a_bj_even: assert final (!(opcode == rv_decode_pkg::OPC_BRANCH ||
                               opcode == rv_decode_pkg::OPC_JAL) || imm_o[0] == 1'b0);

endmodule

`default_nettype wire

// File: hdl/op_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module op_decoder (
    input  wire rv_decode_pkg::instr_t instr_i,    // Instruction word
    output rv_decode_pkg::exe_ctrl_t   exe_ctrl_o  // Execute controls
);

    rv_decode_pkg::opcode_e opcode;     // Major opcode
    rv_decode_pkg::funct3_t funct3;     // Minor opcode
    logic                   funct7_b5;  // SUB and SRA select
    logic                   rd_nz;      // Destination is not x0

    assign opcode    = rv_decode_pkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rd_nz     = instr_i[11:7] != '0;  // Writes to x0 are dropped here

    always_comb begin
        exe_ctrl_o             = '0;  // All controls inactive
        exe_ctrl_o.alu_op      = rv_decode_pkg::ALU_OP_ADD;
        exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_REGS;
        exe_ctrl_o.br_op       = rv_decode_pkg::BR_NOOP;
        case (opcode)
            rv_decode_pkg::OPC_LUI: begin
                exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_IMM_RS1;  // x0 plus immediate
                exe_ctrl_o.regfile_wr  = rd_nz;
            end
            rv_decode_pkg::OPC_AUIPC: begin
                exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_IMM_PC;  // PC plus upper immediate
                exe_ctrl_o.regfile_wr  = rd_nz;
            end
            rv_decode_pkg::OPC_JAL: begin
                exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_IMM_PC;  // Target is PC relative
                exe_ctrl_o.regfile_wr  = rd_nz;                      // Link address into rd
                exe_ctrl_o.jump        = 1'b1;
            end
            rv_decode_pkg::OPC_JALR: begin
                exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_IMM_PC;
                exe_ctrl_o.regfile_wr  = rd_nz;
                exe_ctrl_o.rs1_used    = 1'b1;  // Base of the target
                exe_ctrl_o.jump        = 1'b1;
                exe_ctrl_o.jalr        = 1'b1;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                exe_ctrl_o.rs1_used = 1'b1;  // Compared operands
                exe_ctrl_o.rs2_used = 1'b1;
                case (funct3)
                    rv_decode_pkg::FUNCT3_BEQ:  exe_ctrl_o.br_op = rv_decode_pkg::BR_EQ;
                    rv_decode_pkg::FUNCT3_BNE:  exe_ctrl_o.br_op = rv_decode_pkg::BR_NE;
                    rv_decode_pkg::FUNCT3_BLT:  exe_ctrl_o.br_op = rv_decode_pkg::BR_LT;
                    rv_decode_pkg::FUNCT3_BGE:  exe_ctrl_o.br_op = rv_decode_pkg::BR_GE;
                    rv_decode_pkg::FUNCT3_BLTU: exe_ctrl_o.br_op = rv_decode_pkg::BR_LTU;
                    rv_decode_pkg::FUNCT3_BGEU: exe_ctrl_o.br_op = rv_decode_pkg::BR_GEU;
                    default:                    exe_ctrl_o.br_op = rv_decode_pkg::BR_NOOP;
                endcase
            end
            rv_decode_pkg::OPC_LOAD: begin
                exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_IMM_RS1;  // Address is rs1 plus offset
                exe_ctrl_o.regfile_wr  = rd_nz;
                exe_ctrl_o.rs1_used    = 1'b1;
            end
            rv_decode_pkg::OPC_STORE: begin
                exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_IMM_RS1;
                exe_ctrl_o.rs1_used    = 1'b1;  // Address base
                exe_ctrl_o.rs2_used    = 1'b1;  // Store data
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                exe_ctrl_o.operand_sel = rv_decode_pkg::SEL_IMM_RS1;
                exe_ctrl_o.alu_op      = {funct7_b5, funct3};  // Execute ignores bit 3 on ADDI
                exe_ctrl_o.regfile_wr  = rd_nz;
                exe_ctrl_o.rs1_used    = 1'b1;
            end
            rv_decode_pkg::OPC_OP: begin
                exe_ctrl_o.alu_op     = {funct7_b5, funct3};
                exe_ctrl_o.regfile_wr = rd_nz;
                exe_ctrl_o.rs1_used   = 1'b1;
                exe_ctrl_o.rs2_used   = 1'b1;
            end
            rv_decode_pkg::OPC_SYSTEM: begin
                exe_ctrl_o.csr_op     = funct3;           // Bit 2 picks the immediate form
                exe_ctrl_o.csr_wr     = |funct3;          // Zero is ECALL or EBREAK
                exe_ctrl_o.regfile_wr = rd_nz & |funct3;  // Old CSR value goes to rd
                exe_ctrl_o.rs1_used   = ~funct3[2];
            end
            default: begin
                exe_ctrl_o.regfile_wr = 1'b0;  // FENCE and unknown codes do nothing
            end
        endcase
    end

    // JALR is a flavour of jump, never on its own
    a_jalr_jump: assert final (!exe_ctrl_o.jalr || exe_ctrl_o.jump);

    // Only conditional branches carry a condition
    a_br_only: assert final (exe_ctrl_o.br_op == rv_decode_pkg::BR_NOOP ||
                             opcode == rv_decode_pkg::OPC_BRANCH);

endmodule

`default_nettype wire

// File: hdl/mem_access_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access_decoder (
    input  wire rv_decode_pkg::instr_t instr_i,    // Instruction word
    output rv_decode_pkg::mem_ctrl_t   mem_ctrl_o  // Data memory controls
);

    rv_decode_pkg::opcode_e opcode;  // Major opcode
    rv_decode_pkg::funct3_t funct3;  // Access width and sign

    assign opcode = rv_decode_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    always_comb begin
        mem_ctrl_o = '0;  // No access, LB and SB codes, no lanes
        case (opcode)
            rv_decode_pkg::OPC_LOAD: begin
                mem_ctrl_o.is_mem  = 1'b1;
                mem_ctrl_o.data_rd = 1'b1;
                case (funct3)
                    rv_decode_pkg::FUNCT3_LB:  mem_ctrl_o.load_op = rv_decode_pkg::LOAD_LB;
                    rv_decode_pkg::FUNCT3_LH:  mem_ctrl_o.load_op = rv_decode_pkg::LOAD_LH;
                    rv_decode_pkg::FUNCT3_LBU: mem_ctrl_o.load_op = rv_decode_pkg::LOAD_LBU;
                    rv_decode_pkg::FUNCT3_LHU: mem_ctrl_o.load_op = rv_decode_pkg::LOAD_LHU;
                    default:                   mem_ctrl_o.load_op = rv_decode_pkg::LOAD_LW;
                endcase
            end
            rv_decode_pkg::OPC_STORE: begin
                mem_ctrl_o.is_mem  = 1'b1;
                mem_ctrl_o.data_wr = 1'b1;
                case (funct3)
                    rv_decode_pkg::FUNCT3_SB: begin
                        mem_ctrl_o.store_op = rv_decode_pkg::STORE_SB;
                        mem_ctrl_o.byte_en  = 4'b0001;  // Lowest byte lane
                    end
                    rv_decode_pkg::FUNCT3_SH: begin
                        mem_ctrl_o.store_op = rv_decode_pkg::STORE_SH;
                        mem_ctrl_o.byte_en  = 4'b0011;  // Low half
                    end
                    rv_decode_pkg::FUNCT3_SW: begin
                        mem_ctrl_o.store_op = rv_decode_pkg::STORE_SW;
                        mem_ctrl_o.byte_en  = 4'b1111;  // Full word
                    end
                    default: mem_ctrl_o.byte_en = 4'b0000;  // Illegal width writes no lane
                endcase
            end
            default: mem_ctrl_o = '0;
        endcase
    end

    a_rd_wr_excl: assert final (!(mem_ctrl_o.data_rd && mem_ctrl_o.data_wr));

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
    parameter int XLEN = 32  // Datapath width
) (
    input  wire                          clk_i,          // Core clock
    input  wire                          rst_n_i,        // Async reset, active low
    input  wire                          instr_valid_i,  // Instruction strobe
    input  wire rv_decode_pkg::instr_t   instr_i,        // Fetched instruction
    output logic                         valid_o,        // Decoded word valid
    output logic [XLEN-1:0]              imm_o,          // Extended immediate
    output rv_decode_pkg::exe_ctrl_t     exe_ctrl_o,     // To execute
    output rv_decode_pkg::mem_ctrl_t     mem_ctrl_o,     // To memory access
    output rv_decode_pkg::reg_fields_t   fields_o        // Register and CSR fields
);

    logic [XLEN-1:0]            imm_d;       // Immediate before the register
    rv_decode_pkg::exe_ctrl_t   exe_ctrl_d;  // Execute controls before the register
    rv_decode_pkg::mem_ctrl_t   mem_ctrl_d;  // Memory controls before the register
    rv_decode_pkg::reg_fields_t fields_d;    // Sliced fields

    imm_gen #(
        .XLEN (XLEN)
    ) imm_gen_inst (
        .instr_i (instr_i),
        .imm_o   (imm_d)
    );

    op_decoder op_decoder_inst (
        .instr_i    (instr_i),
        .exe_ctrl_o (exe_ctrl_d)
    );

    mem_access_decoder mem_access_decoder_inst (
        .instr_i    (instr_i),
        .mem_ctrl_o (mem_ctrl_d)
    );

    // Fixed bit positions, whatever the format
    assign fields_d.rs1      = instr_i[19:15];
    assign fields_d.rs2      = instr_i[24:20];
    assign fields_d.rd       = instr_i[11:7];
    assign fields_d.csr_addr = instr_i[31:20];
    assign fields_d.csr_imm  = instr_i[19:15];  // Shares the rs1 slot

    // ID/EX control register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o    <= 1'b0;
            exe_ctrl_o <= '0;  // Add, REGS, NOOP
            mem_ctrl_o <= '0;
        end else begin
            valid_o    <= instr_valid_i;
            exe_ctrl_o <= instr_valid_i ? exe_ctrl_d : '0;  // Bubble carries no writes
            mem_ctrl_o <= instr_valid_i ? mem_ctrl_d : '0;
        end
    end

    // Payload only follows a valid instruction
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            imm_o    <= imm_d;
            fields_o <= fields_d;
        end
    end

    a_rst_invalid: assert property (@(posedge clk_i) !rst_n_i |-> !valid_o);

endmodule

`default_nettype wire

// File: verif/tb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decode_stage;

    localparam int XLEN = 32;

    // Opcodes the generator picks from
    localparam logic [6:0] OPCODES [10] = '{
        rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC, rv_decode_pkg::OPC_JAL,
        rv_decode_pkg::OPC_JALR, rv_decode_pkg::OPC_BRANCH, rv_decode_pkg::OPC_LOAD,
        rv_decode_pkg::OPC_STORE, rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_OP,
        rv_decode_pkg::OPC_SYSTEM};

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       instr_valid_i;
    rv_decode_pkg::instr_t      instr_i;
    logic                       valid_o;
    logic [XLEN-1:0]            imm_o;
    rv_decode_pkg::exe_ctrl_t   exe_ctrl_o;
    rv_decode_pkg::mem_ctrl_t   mem_ctrl_o;
    rv_decode_pkg::reg_fields_t fields_o;

    logic                       prev_valid;  // Strobe taken at the last edge
    rv_decode_pkg::instr_t      prev_instr;  // Word taken at the last edge
    logic [XLEN-1:0]            exp_imm;
    rv_decode_pkg::exe_ctrl_t   exp_exe;
    rv_decode_pkg::mem_ctrl_t   exp_mem;
    rv_decode_pkg::reg_fields_t exp_fields;
    logic [31:0]                lfsr;        // Stimulus generator state
    int                         error_cnt;
    int                         fail_tests;
    logic                       timed_out;

    decode_stage #(
        .XLEN (XLEN)
    ) decode_stage_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .valid_o       (valid_o),
        .imm_o         (imm_o),
        .exe_ctrl_o    (exe_ctrl_o),
        .mem_ctrl_o    (mem_ctrl_o),
        .fields_o      (fields_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    // ISA immediate formats, built field by field
    function automatic logic [XLEN-1:0] expect_imm(input rv_decode_pkg::instr_t w);
        logic [12:0] b_off;
        logic [20:0] j_off;
        b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (w[6:0])
            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: return {w[31:12], 12'h000};
            rv_decode_pkg::OPC_JALR, rv_decode_pkg::OPC_LOAD,
            rv_decode_pkg::OPC_OP_IMM: return {{20{w[31]}}, w[31:20]};
            rv_decode_pkg::OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            rv_decode_pkg::OPC_BRANCH: return {{19{b_off[12]}}, b_off};
            rv_decode_pkg::OPC_JAL:    return {{11{j_off[20]}}, j_off};
            default:                   return '0;
        endcase
    endfunction

    function automatic rv_decode_pkg::exe_ctrl_t expect_exe(input rv_decode_pkg::instr_t w);
        rv_decode_pkg::exe_ctrl_t c;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       rd_nz;
        logic       is_sys;
        opc    = w[6:0];
        f3     = w[14:12];
        rd_nz  = w[11:7] != 5'd0;
        is_sys = opc == rv_decode_pkg::OPC_SYSTEM;
        c      = '0;  // Add, REGS and NOOP are all zero codes
        c.regfile_wr = rd_nz && ((is_sys && f3 != 3'd0) || opc inside {
            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC, rv_decode_pkg::OPC_JAL,
            rv_decode_pkg::OPC_JALR, rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_OP_IMM,
            rv_decode_pkg::OPC_OP});
        c.rs1_used = (is_sys && !f3[2]) || opc inside {rv_decode_pkg::OPC_JALR,
            rv_decode_pkg::OPC_BRANCH, rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_STORE,
            rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_OP};
        c.rs2_used = opc inside {rv_decode_pkg::OPC_BRANCH, rv_decode_pkg::OPC_STORE,
            rv_decode_pkg::OPC_OP};
        c.jump = opc inside {rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR};
        c.jalr = opc == rv_decode_pkg::OPC_JALR;
        if (opc inside {rv_decode_pkg::OPC_OP, rv_decode_pkg::OPC_OP_IMM})
            c.alu_op = {w[30], f3};  // funct7 bit 5 over funct3
        if (opc inside {rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_LOAD,
                        rv_decode_pkg::OPC_STORE, rv_decode_pkg::OPC_OP_IMM})
            c.operand_sel = rv_decode_pkg::SEL_IMM_RS1;
        else if (opc inside {rv_decode_pkg::OPC_AUIPC, rv_decode_pkg::OPC_JAL,
                             rv_decode_pkg::OPC_JALR})
            c.operand_sel = rv_decode_pkg::SEL_IMM_PC;
        if (opc == rv_decode_pkg::OPC_BRANCH) begin
            case (f3)
                3'd0:    c.br_op = rv_decode_pkg::BR_EQ;
                3'd1:    c.br_op = rv_decode_pkg::BR_NE;
                3'd4:    c.br_op = rv_decode_pkg::BR_LT;
                3'd5:    c.br_op = rv_decode_pkg::BR_GE;
                3'd6:    c.br_op = rv_decode_pkg::BR_LTU;
                3'd7:    c.br_op = rv_decode_pkg::BR_GEU;
                default: c.br_op = rv_decode_pkg::BR_NOOP;  // Codes 2 and 3 unused
            endcase
        end
        if (is_sys) begin
            c.csr_op = f3;
            c.csr_wr = f3 != 3'd0;
        end
        return c;
    endfunction

    function automatic rv_decode_pkg::mem_ctrl_t expect_mem(input rv_decode_pkg::instr_t w);
        rv_decode_pkg::mem_ctrl_t m;
        m = '0;
        if (w[6:0] == rv_decode_pkg::OPC_LOAD) begin
            m.is_mem  = 1'b1;
            m.data_rd = 1'b1;
            case (w[14:12])
                3'd0:    m.load_op = rv_decode_pkg::LOAD_LB;
                3'd1:    m.load_op = rv_decode_pkg::LOAD_LH;
                3'd4:    m.load_op = rv_decode_pkg::LOAD_LBU;
                3'd5:    m.load_op = rv_decode_pkg::LOAD_LHU;
                default: m.load_op = rv_decode_pkg::LOAD_LW;  // Illegal widths read a word
            endcase
        end else if (w[6:0] == rv_decode_pkg::OPC_STORE) begin
            m.is_mem  = 1'b1;
            m.data_wr = 1'b1;
            case (w[14:12])
                3'd0: begin
                    m.store_op = rv_decode_pkg::STORE_SB;
                    m.byte_en  = 4'b0001;
                end
                3'd1: begin
                    m.store_op = rv_decode_pkg::STORE_SH;
                    m.byte_en  = 4'b0011;
                end
                3'd2: begin
                    m.store_op = rv_decode_pkg::STORE_SW;
                    m.byte_en  = 4'b1111;
                end
                default: m.byte_en = 4'b0000;  // No lane for an illegal width
            endcase
        end
        return m;
    endfunction

    // Model of the ID/EX boundary, one word per rising edge
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_valid <= 1'b0;
            prev_instr <= '0;
        end else begin
            prev_valid <= instr_valid_i;
            prev_instr <= instr_i;
        end
    end

    assign exp_imm    = expect_imm(prev_instr);
    assign exp_exe    = expect_exe(prev_instr);
    assign exp_mem    = expect_mem(prev_instr);
    assign exp_fields = {prev_instr[19:15], prev_instr[24:20], prev_instr[11:7],
                         prev_instr[31:20], prev_instr[19:15]};  // rs1 rs2 rd csr_addr csr_imm

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_cnt++;
        $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    a_reset_low: assert property (@(posedge clk_i) !rst_n_i |-> !valid_o)
        else report_mismatch("valid_o", 32'($sampled(valid_o)), 32'd0);
    a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_o == prev_valid)
        else report_mismatch("valid_o", 32'($sampled(valid_o)), 32'($sampled(prev_valid)));
    a_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !prev_valid |-> {exe_ctrl_o, mem_ctrl_o} == '0)
        else report_mismatch("exe_ctrl_o/mem_ctrl_o",
                             32'({$sampled(exe_ctrl_o), $sampled(mem_ctrl_o)}), 32'd0);
    a_imm: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> imm_o == exp_imm)
        else report_mismatch("imm_o", 32'($sampled(imm_o)), 32'($sampled(exp_imm)));
    a_fields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> fields_o == exp_fields)
        else report_mismatch("fields_o", 32'($sampled(fields_o)), 32'($sampled(exp_fields)));
    a_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> mem_ctrl_o == exp_mem)
        else report_mismatch("mem_ctrl_o", 32'($sampled(mem_ctrl_o)), 32'($sampled(exp_mem)));
    a_regfile_wr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> exe_ctrl_o.regfile_wr == exp_exe.regfile_wr)
        else report_mismatch("exe_ctrl_o.regfile_wr", 32'($sampled(exe_ctrl_o.regfile_wr)),
                             32'($sampled(exp_exe.regfile_wr)));
    a_alu: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> {exe_ctrl_o.alu_op, exe_ctrl_o.operand_sel} ==
                       {exp_exe.alu_op, exp_exe.operand_sel})
        else report_mismatch("exe_ctrl_o.alu_op/operand_sel",
            32'({$sampled(exe_ctrl_o.alu_op), $sampled(exe_ctrl_o.operand_sel)}),
            32'({$sampled(exp_exe.alu_op), $sampled(exp_exe.operand_sel)}));
    a_flow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> {exe_ctrl_o.br_op, exe_ctrl_o.jump, exe_ctrl_o.jalr} ==
                       {exp_exe.br_op, exp_exe.jump, exp_exe.jalr})
        else report_mismatch("exe_ctrl_o.br_op/jump/jalr",
            32'({$sampled(exe_ctrl_o.br_op), $sampled(exe_ctrl_o.jump), $sampled(exe_ctrl_o.jalr)}),
            32'({$sampled(exp_exe.br_op), $sampled(exp_exe.jump), $sampled(exp_exe.jalr)}));
    a_used: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> {exe_ctrl_o.rs1_used, exe_ctrl_o.rs2_used} ==
                       {exp_exe.rs1_used, exp_exe.rs2_used})
        else report_mismatch("exe_ctrl_o.rs1_used/rs2_used",
            32'({$sampled(exe_ctrl_o.rs1_used), $sampled(exe_ctrl_o.rs2_used)}),
            32'({$sampled(exp_exe.rs1_used), $sampled(exp_exe.rs2_used)}));
    a_csr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_valid |-> {exe_ctrl_o.csr_op, exe_ctrl_o.csr_wr} == {exp_exe.csr_op, exp_exe.csr_wr})
        else report_mismatch("exe_ctrl_o.csr_op/csr_wr",
            32'({$sampled(exe_ctrl_o.csr_op), $sampled(exe_ctrl_o.csr_wr)}),
            32'({$sampled(exp_exe.csr_op), $sampled(exp_exe.csr_wr)}));

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic make_instr(output rv_decode_pkg::instr_t w);
        logic [31:0] bits;
        logic [31:0] pick;
        logic [31:0] zero_rd;
        int          idx;
        take_bits(32, bits);
        take_bits(4, pick);
        take_bits(2, zero_rd);
        idx = int'(pick % 10);
        w   = bits;
        w[6:0] = OPCODES[idx];
        if (zero_rd == 32'd0) w[11:7] = 5'd0;  // x0 destination on about a quarter
    endtask

    task automatic close_test(input string name, input int sent, input int start_err);
        $display("Test %s: %0d instructions, %0d errors", name, sent, error_cnt - start_err);
        if (error_cnt != start_err) fail_tests++;
    endtask

    // Back to back words, with optional idle cycles carrying junk
    task automatic run_burst(input string name, input int count, input logic gaps);
        rv_decode_pkg::instr_t w;
        logic [31:0] gap;
        int          sent;
        int          cycles;
        int          start_err;
        sent      = 0;
        cycles    = 0;
        start_err = error_cnt;
        while (sent < count && cycles < 4 * count) begin
            make_instr(w);
            instr_i       = w;
            instr_valid_i = 1'b1;
            if (gaps) begin
                take_bits(2, gap);
                if (gap == 32'd0) instr_valid_i = 1'b0;
            end
            if (instr_valid_i) sent++;
            cycles++;
            @(negedge clk_i);
        end
        instr_valid_i = 1'b0;
        if (sent < count) begin
            $display("Test %s stopped: only %0d of %0d words sent in time", name, sent, count);
            timed_out = 1'b1;
        end
        repeat (2) @(negedge clk_i);  // Let the last word reach its check
        close_test(name, sent, start_err);
    endtask

    task automatic wait_valid_out(input int limit);
        int waited;
        waited = 0;
        while (!valid_o && waited < limit) begin
            @(negedge clk_i);
            waited++;
        end
        if (!valid_o) begin
            $display("Timeout: valid_o did not rise within %0d cycles at t=%0t", limit, $time);
            timed_out = 1'b1;
        end
    endtask

    // One word, then wait for it to come out
    task automatic run_single(input string name, input int count);
        rv_decode_pkg::instr_t w;
        int sent;
        int start_err;
        sent      = 0;
        start_err = error_cnt;
        for (int n = 0; n < count && !timed_out; n++) begin
            make_instr(w);
            instr_i       = w;
            instr_valid_i = 1'b1;
            @(negedge clk_i);
            instr_valid_i = 1'b0;
            sent++;
            wait_valid_out(4);
            @(negedge clk_i);  // Idle cycle, output drops again
        end
        repeat (2) @(negedge clk_i);
        close_test(name, sent, start_err);
    endtask

    initial begin
        error_cnt     = 0;
        fail_tests    = 0;
        timed_out     = 1'b0;
        lfsr          = 32'h4fa8;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (8) @(negedge clk_i);  // Eight cycles in reset
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk_i);
        close_test("reset", 0, 0);
        run_burst("dense", 400, 1'b0);
        run_burst("gaps", 400, 1'b1);
        run_single("single", 60);
        $display("Tests run: 4, failed: %0d, errors: %0d", fail_tests, error_cnt);
        if (error_cnt == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/rv_decode_pkg.sv
hdl/imm_gen.sv
hdl/op_decoder.sv
hdl/mem_access_decoder.sv
hdl/decode_stage.sv
verif/tb_decode_stage.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_decode_stage
FILELIST = compile.f
LOG      = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
